//--- macro_fetch.f
+incdir+testbench
source/machine_word_pkg.sv
source/fetch_control_pkg.sv
source/cycle_sequencer.sv
source/location_counter.sv
source/instruction_buffer.sv
source/macroinstruction_extractor.sv
source/macro_fetch_top.sv
testbench/macro_fetch_tb.sv

//--- Makefile
# Verilator build and run of the macroinstruction fetch path testbench

VERILATOR ?= verilator
TOP       ?= macro_fetch_tb
FILELIST  ?= macro_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/macro_fetch_model.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result; a crash still fails through the exit status
run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/macro_fetch_model.svh
// Reference model of the fetch path, included inside the testbench module.
// Holds the LCG, the memory image and the round-level prediction of lc,
// needfetch, reads, readback and issued macroinstructions.

`ifndef MACRO_FETCH_MODEL_SVH
`define MACRO_FETCH_MODEL_SVH

// Outcome of one fetch, mmu, write, alu round
typedef struct packed {
   machine_word_pkg::lc_t       lc;
   logic                        needfetch;
   logic                        issue;
   machine_word_pkg::halfword_t instr;
} round_result_t;

// Values expected in the alu phase
typedef struct packed {
   machine_word_pkg::lc_t        lc;
   machine_word_pkg::word_t      mf;
   logic                         read;
   machine_word_pkg::word_addr_t addr;
} alu_expect_t;

function automatic logic [31:0] lcg_next(input logic [31:0] seed);
   return seed * 32'd1103515245 + 32'd12345;
endfunction

// Memory image as a hash over the whole word address
function automatic machine_word_pkg::word_t mem_word(input machine_word_pkg::word_addr_t addr);
   return ({8'h00, addr} * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
endfunction

function automatic machine_word_pkg::halfword_t extract_instr(
   input machine_word_pkg::word_t word, input machine_word_pkg::lc_t lc, input logic byte_mode);
   if (byte_mode) begin
      return {8'h00, word[{lc[1:0], 3'b000} +: 8]};
   end
   return lc[1] ? word[31:16] : word[15:0];
endfunction

// One round from the LC rules; needfetch is always clear once a round ends
function automatic round_result_t predict_round(
   input machine_word_pkg::lc_t lc_in, input logic nf_in,
   input fetch_control_pkg::lc_ctrl_t c, input machine_word_pkg::word_t ob_value);
   round_result_t r;
   if (c.destlc) begin
      r.lc = ob_value[machine_word_pkg::LC_WIDTH-1:0];
   end else if (c.lcinc) begin
      r.lc = lc_in + (c.lc_byte_mode ? 26'd1 : 26'd2);
   end else begin
      r.lc = lc_in;
   end
   r.needfetch = nf_in | c.destlc | (r.lc[25:2] != lc_in[25:2]);
   r.issue = ~r.needfetch;
   r.instr = extract_instr(mem_word(r.lc[25:2]), r.lc, c.lc_byte_mode);
   return r;
endfunction

function automatic machine_word_pkg::word_t expected_mf(
   input fetch_control_pkg::mf_source_t sel, input round_result_t r,
   input fetch_control_pkg::lc_ctrl_t c, input machine_word_pkg::word_t md_now);
   case (sel)
      fetch_control_pkg::MF_LC: begin
         return {r.needfetch, 1'b0, c.lc_byte_mode, 1'b0,
                 c.int_enable, c.sequence_break, r.lc};
      end
      fetch_control_pkg::MF_MD:  return md_now;
      fetch_control_pkg::MF_VMA: return {8'h00, r.lc[25:2]};
      default:                   return '0;
   endcase
endfunction

`endif

//--- testbench/macro_fetch_tb.sv
// Testbench for the macroinstruction fetch path.
// Plays whole microcycle rounds against the DUT, models memory with a
// one-cycle answer and compares lc, mf, reads and strobes with the model.

`timescale 1ns/1ps
`default_nettype none

module macro_fetch_tb;

   `include "macro_fetch_model.svh"

   localparam int DRAIN_LIMIT   = 16;
   localparam int RANDOM_ROUNDS = 300;

   logic                            clk;
   logic                            reset;
   logic                            run;
   fetch_control_pkg::lc_ctrl_t     ctrl;
   machine_word_pkg::word_t         ob;
   fetch_control_pkg::mf_source_t   mf_sel;
   fetch_control_pkg::mem_resp_t    mem_resp = '0;
   fetch_control_pkg::mem_req_t     mem_req;
   machine_word_pkg::lc_t           lc;
   machine_word_pkg::word_t         mf;
   fetch_control_pkg::macro_instr_t instr_out;

   // Model state advanced once per round
   machine_word_pkg::lc_t           model_lc;
   logic                            model_nf;
   machine_word_pkg::word_t         model_md;
   logic                            running;
   logic [31:0]                     rng;

   fetch_control_pkg::macro_instr_t exp_q[$];
   int                              next_exp = 0;
   alu_expect_t                     alu_exp;
   int                              alu_rounds = 0;
   int                              alu_seen = 0;
   int                              read_count = 0;
   int                              read_base = 0;
   machine_word_pkg::word_addr_t    last_read_addr = '0;
   int                              test_errors = 0;
   int                              compare_errors = 0;
   int                              tests_run = 0;
   int                              tests_failed = 0;
   int                              errors_at_start = 0;

   macro_fetch_top macro_fetch_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Memory answers every read one clock later
   always @(posedge clk) begin
      if (reset) begin
         mem_resp <= '0;
      end else begin
         mem_resp.valid <= mem_req.read;
         mem_resp.data  <= mem_req.read ? mem_word(mem_req.addr) : '0;
         if (mem_req.read) begin
            read_count++;
            last_read_addr = mem_req.addr;
         end
      end
   end

   function automatic int check_value(input string name, input logic [31:0] got,
                                      input logic [31:0] exp);
      int bad;
      bad = 0;
      assert (got === exp) else begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         bad = 1;
      end
      return bad;
   endfunction

   function automatic int check_true(input logic cond, input string what);
      int bad;
      bad = 0;
      assert (cond) else begin
         $display("ERROR %s", what);
         bad = 1;
      end
      return bad;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare process
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (!reset && instr_out.strobe) begin
         if (next_exp >= exp_q.size()) begin
            compare_errors += check_true(1'b0, "instruction strobe with none expected");
         end else begin
            compare_errors += check_value("instr_out", 32'(instr_out), 32'(exp_q[next_exp]));
            next_exp++;
         end
      end
      // Alu phase of a round
      if (alu_seen != alu_rounds) begin
         alu_seen = alu_rounds;
         compare_errors += check_value("lc", 32'(lc), 32'(alu_exp.lc));
         compare_errors += check_value("mf", mf, alu_exp.mf);
         compare_errors += check_value("mem_req.read", 32'(read_count - read_base),
                                       32'(alu_exp.read));
         if (alu_exp.read) begin
            compare_errors += check_value("mem_req.addr", 32'(last_read_addr),
                                          32'(alu_exp.addr));
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Round stimulus
   //////////////////////////////////////////////////////////////////////

   function automatic fetch_control_pkg::lc_ctrl_t lc_controls(
      input logic destlc, input logic lcinc, input logic byte_mode,
      input logic int_enable, input logic sequence_break);
      return {destlc, lcinc, byte_mode, int_enable, sequence_break};
   endfunction

   // Drives one round from its fetch edge and hands the alu values over
   task automatic play_round(input fetch_control_pkg::lc_ctrl_t c,
                             input machine_word_pkg::word_t ob_value,
                             input fetch_control_pkg::mf_source_t sel, input logic keep_run);
      round_result_t r;
      if (!running) begin
         @(posedge clk);
         run <= 1'b1;
      end
      @(posedge clk);
      ctrl   <= c;
      ob     <= ob_value;
      mf_sel <= sel;
      run    <= keep_run;
      r = predict_round(model_lc, model_nf, c, ob_value);
      read_base = read_count;
      alu_exp.lc = r.lc;
      alu_exp.mf = expected_mf(sel, r, c, model_md);
      alu_exp.read = r.needfetch;
      alu_exp.addr = r.lc[25:2];
      if (r.issue) begin
         exp_q.push_back({1'b1, c.lc_byte_mode, r.instr});
      end
      repeat (3) @(posedge clk);
      alu_rounds++;
      model_lc = r.lc;
      model_nf = 1'b0;
      if (r.needfetch) begin
         model_md = mem_word(r.lc[25:2]);
      end
      running = keep_run;
   endtask

   // Last round drops run, then waits for the pending strobes
   task automatic finish_rounds();
      int waited;
      waited = 0;
      play_round(lc_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0), '0,
                 fetch_control_pkg::MF_NONE, 1'b0);
      while (next_exp != exp_q.size() && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      test_errors += check_true(next_exp == exp_q.size(),
                                "expected instruction strobe never arrived");
   endtask

   task automatic start_test();
      errors_at_start = test_errors + compare_errors;
      tests_run++;
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = test_errors + compare_errors - errors_at_start;
      if (errs == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errs);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////////////////////////

   initial begin
      fetch_control_pkg::lc_ctrl_t c;
      logic [31:0]                 draw;
      logic [31:0]                 ob_draw;
      reset = 1'b1;
      run = 1'b0;
      ctrl = '0;
      ob = '0;
      mf_sel = fetch_control_pkg::MF_NONE;
      model_lc = '0;
      model_nf = 1'b1;
      model_md = '0;
      running = 1'b0;
      rng = 32'd14;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      mf_sel <= fetch_control_pkg::MF_LC;

      start_test();
      repeat (3) @(posedge clk);
      @(negedge clk);
      test_errors += check_value("lc", 32'(lc), 32'h0);
      test_errors += check_value("mem_req.read", 32'(mem_req.read), 32'h0);
      test_errors += check_value("instr_out.strobe", 32'(instr_out.strobe), 32'h0);
      test_errors += check_value("read count", 32'(read_count), 32'h0);
      // Status word is nonzero here, but mf stays zero while idle
      test_errors += check_value("mf", mf, 32'h0);
      c = lc_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      play_round(c, '0, fetch_control_pkg::MF_VMA, 1'b1);
      play_round(c, '0, fetch_control_pkg::MF_MD, 1'b1);
      finish_rounds();
      end_test("reset and first fetch");

      start_test();
      for (int i = 0; i < 12; i++) begin
         play_round(lc_controls(1'b0, 1'b1, 1'b0, 1'b0, 1'b0), '0,
                    fetch_control_pkg::MF_LC, 1'b1);
      end
      finish_rounds();
      end_test("halfword increments");

      // Byte steps across 0x200, then across the top of the address space
      start_test();
      c = lc_controls(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
      play_round(lc_controls(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 32'h0000_01fa,
                 fetch_control_pkg::MF_VMA, 1'b1);
      for (int i = 0; i < 12; i++) play_round(c, '0, fetch_control_pkg::MF_VMA, 1'b1);
      play_round(lc_controls(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), 32'h03ff_fffd,
                 fetch_control_pkg::MF_LC, 1'b1);
      for (int i = 0; i < 4; i++) play_round(c, '0, fetch_control_pkg::MF_LC, 1'b1);
      finish_rounds();
      end_test("byte mode with carry");

      start_test();
      c = lc_controls(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      for (int i = 0; i < 4; i++) play_round(c, '0, fetch_control_pkg::MF_LC, 1'b1);
      play_round(lc_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 32'hfc12_3456,
                 fetch_control_pkg::MF_LC, 1'b1);
      for (int i = 0; i < 3; i++) play_round(c, '0, fetch_control_pkg::MF_VMA, 1'b1);
      // Load inside the word already held
      play_round(lc_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), 32'h0012_345e,
                 fetch_control_pkg::MF_LC, 1'b1);
      for (int i = 0; i < 2; i++) play_round(c, '0, fetch_control_pkg::MF_MD, 1'b1);
      finish_rounds();
      end_test("destlc load");

      start_test();
      for (int i = 0; i < 8; i++) begin
         play_round(lc_controls(1'b0, 1'b1, i[2], i[0], 1'b1), '0,
                    fetch_control_pkg::mf_source_t'(i[1:0]), 1'b1);
      end
      finish_rounds();
      end_test("mf readback");

      start_test();
      for (int i = 0; i < RANDOM_ROUNDS; i++) begin
         rng = lcg_next(rng);
         draw = rng;
         rng = lcg_next(rng);
         ob_draw = rng;
         c = lc_controls(draw[31:29] == 3'd0, draw[28] | draw[27], draw[26],
                         draw[25], draw[24]);
         play_round(c, ob_draw, fetch_control_pkg::mf_source_t'(draw[23:22]),
                    draw[21:18] != 4'd0);
      end
      finish_rounds();
      end_test("random rounds");

      $display("tests run %0d, tests failed %0d, check errors %0d",
               tests_run, tests_failed, test_errors + compare_errors);
      if (test_errors + compare_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- source/macro_fetch_top.sv
// Top level of the macroinstruction fetch path.
// Ties the sequencer, location counter, instruction buffer and extractor
// together; memory sits outside on mem_req and mem_resp.

`timescale 1ns/1ps
`default_nettype none

module macro_fetch_top (
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic                          run,
   input  fetch_control_pkg::lc_ctrl_t        ctrl,
   input  machine_word_pkg::word_t            ob,
   input  fetch_control_pkg::mf_source_t      mf_sel,
   input  fetch_control_pkg::mem_resp_t       mem_resp,
   output fetch_control_pkg::mem_req_t        mem_req,
   output machine_word_pkg::lc_t              lc,
   output machine_word_pkg::word_t            mf,
   output fetch_control_pkg::macro_instr_t    instr_out
);

   fetch_control_pkg::machine_state_t state;
   machine_word_pkg::word_t           md;
   logic                              needfetch;

   cycle_sequencer cycle_sequencer_i (
      .clk   (clk),
      .reset (reset),
      .run   (run),
      .state (state)
   );

   location_counter location_counter_i (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .ctrl      (ctrl),
      .ob        (ob),
      .mem_resp  (mem_resp),
      .md        (md),
      .mf_sel    (mf_sel),
      .lc        (lc),
      .needfetch (needfetch),
      .mem_req   (mem_req),
      .mf        (mf)
   );

   instruction_buffer instruction_buffer_i (
      .clk      (clk),
      .reset    (reset),
      .mem_resp (mem_resp),
      .md       (md)
   );

   macroinstruction_extractor macroinstruction_extractor_i (
      .clk          (clk),
      .reset        (reset),
      .state        (state),
      .lc           (lc),
      .lc_byte_mode (ctrl.lc_byte_mode),
      .needfetch    (needfetch),
      .md           (md),
      .instr_out    (instr_out)
   );

endmodule

`default_nettype wire

//--- source/macroinstruction_extractor.sv
// Macroinstruction extractor.
// In the alu phase, once the word under the LC is buffered, picks the
// halfword or zero-extended byte the LC points at and strobes it out.

`timescale 1ns/1ps
`default_nettype none

module macroinstruction_extractor (
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  fetch_control_pkg::machine_state_t      state,
   input  machine_word_pkg::lc_t                  lc,
   input  wire logic                              lc_byte_mode,
   input  wire logic                              needfetch,
   input  machine_word_pkg::word_t                md,
   output fetch_control_pkg::macro_instr_t        instr_out
);

   logic                        issue;
   machine_word_pkg::halfword_t selected;

   assign issue = (state == fetch_control_pkg::S_ALU) && !needfetch;

   always_comb begin
      if (lc_byte_mode) begin
         case (lc[1:0])
            2'd0:    selected = {8'b0, md[7:0]};
            2'd1:    selected = {8'b0, md[15:8]};
            2'd2:    selected = {8'b0, md[23:16]};
            default: selected = {8'b0, md[31:24]};
         endcase
      end else begin
         selected = lc[1] ? md[31:16] : md[15:0];
      end
   end

   // Strobe lands in the fetch phase after the alu that chose it
   always_ff @(posedge clk) begin
      if (reset) begin
         instr_out.strobe <= 1'b0;
      end else begin
         instr_out.strobe <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         instr_out.instr     <= selected;
         instr_out.byte_mode <= lc_byte_mode;
      end
   end

endmodule

`default_nettype wire

//--- source/instruction_buffer.sv
// Instruction word buffer that serves as the md register of the fetch path.
// Captures the word memory returns on the valid strobe and holds it for
// the extractor and for mf readback.

`timescale 1ns/1ps
`default_nettype none

module instruction_buffer (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  fetch_control_pkg::mem_resp_t     mem_resp,
   output machine_word_pkg::word_t          md
);

   //////////////////////////////////////////////////////////////////////
   // Word latch
   //////////////////////////////////////////////////////////////////////

   // Only a valid beat from memory overwrites the held word
   always_ff @(posedge clk) begin
      if (reset) begin
         md <= '0;
      end else if (mem_resp.valid) begin
         md <= mem_resp.data;
      end
   end

endmodule

`default_nettype wire

//--- source/location_counter.sv
// Location counter of the macroinstruction fetch path.
// Holds the byte address of the next macroinstruction, loads it from the
// result bus or steps it by a byte or a halfword, and requests a memory
// read when the word under it has not been fetched yet. Also drives mf.

`timescale 1ns/1ps
`default_nettype none

module location_counter (
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  fetch_control_pkg::machine_state_t      state,
   input  fetch_control_pkg::lc_ctrl_t            ctrl,
   input  machine_word_pkg::word_t                ob,
   input  fetch_control_pkg::mem_resp_t           mem_resp,
   input  machine_word_pkg::word_t                md,
   input  fetch_control_pkg::mf_source_t          mf_sel,
   output machine_word_pkg::lc_t                  lc,
   output logic                                   needfetch,
   output fetch_control_pkg::mem_req_t            mem_req,
   output machine_word_pkg::word_t                mf
);

   // Low nibble sum with the carry into lc[25:4] in bit 4
   logic [4:0]               low_sum;
   machine_word_pkg::lc_t    lc_stepped;
   machine_word_pkg::lc_t    lc_next;
   logic                     word_changed;
   logic                     in_fetch;

   assign in_fetch = (state == fetch_control_pkg::S_FETCH);

   //////////////////////////////////////////////////////////////////////
   // Increment
   //////////////////////////////////////////////////////////////////////

   // Halfword mode adds the lcinc bit twice
   assign low_sum = {1'b0, lc[3:0]}
                  + {4'b0, ctrl.lcinc & ~ctrl.lc_byte_mode}
                  + {4'b0, ctrl.lcinc};

   assign lc_stepped = {lc[25:4] + {21'b0, low_sum[4]}, low_sum[3:0]};

   assign lc_next = ctrl.destlc ? ob[machine_word_pkg::LC_WIDTH-1:0] : lc_stepped;

   // Set when a step moves lc into another word
   assign word_changed = (lc_stepped[25:2] != lc[25:2]);

   always_ff @(posedge clk) begin
      if (reset) begin
         lc <= '0;
      end else if (in_fetch) begin
         lc <= lc_next;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Fetch flag and memory read
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         needfetch <= 1'b1;
      end else if (in_fetch && (ctrl.destlc || word_changed)) begin
         needfetch <= 1'b1;
      end else if (mem_resp.valid) begin
         needfetch <= 1'b0;
      end
   end

   // Read goes out in write, decided from the flag seen in mmu
   always_ff @(posedge clk) begin
      if (reset) begin
         mem_req.read <= 1'b0;
      end else begin
         mem_req.read <= (state == fetch_control_pkg::S_MMU) && needfetch;
      end
   end

   always_ff @(posedge clk) begin
      if (state == fetch_control_pkg::S_MMU) begin
         mem_req.addr <= lc[25:2];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // mf readback
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      mf = '0;
      if (state != fetch_control_pkg::S_IDLE) begin
         case (mf_sel)
            fetch_control_pkg::MF_LC: begin
               // Unibus reset bit is not implemented here and reads 0
               mf = {needfetch, 1'b0, ctrl.lc_byte_mode, 1'b0,
                     ctrl.int_enable, ctrl.sequence_break, lc[25:1], lc[0]};
            end
            fetch_control_pkg::MF_MD: begin
               mf = md;
            end
            fetch_control_pkg::MF_VMA: begin
               mf = {8'b0, lc[25:2]};
            end
            default: begin
               mf = '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/cycle_sequencer.sv
// Microcycle sequencer of the fetch path.
// Walks fetch, mmu, write and alu one clock each while run is high, and
// always completes the current round before going back to idle.

`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  wire logic                              run,
   output fetch_control_pkg::machine_state_t      state
);

   fetch_control_pkg::machine_state_t state_next;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= fetch_control_pkg::S_IDLE;
      end else begin
         state <= state_next;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Next state
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      case (state)
         fetch_control_pkg::S_IDLE: begin
            state_next = run ? fetch_control_pkg::S_FETCH : fetch_control_pkg::S_IDLE;
         end
         fetch_control_pkg::S_FETCH: begin
            state_next = fetch_control_pkg::S_MMU;
         end
         fetch_control_pkg::S_MMU: begin
            state_next = fetch_control_pkg::S_WRITE;
         end
         fetch_control_pkg::S_WRITE: begin
            state_next = fetch_control_pkg::S_ALU;
         end
         fetch_control_pkg::S_ALU: begin
            // Round boundary is the only place run is sampled
            state_next = run ? fetch_control_pkg::S_FETCH : fetch_control_pkg::S_IDLE;
         end
         default: begin
            state_next = fetch_control_pkg::S_IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/fetch_control_pkg.sv
// Control encodings and bundled transfers of the macroinstruction fetch path.
// Covers the microcycle state, the mf readback select, the LC control bits
// and the memory and instruction transfer structs.

`default_nettype none

package fetch_control_pkg;

   //////////////////////////////////////////////////////////////////////
   // One-hot microcycle state
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [4:0] {
      S_IDLE  = 5'b00001,
      S_FETCH = 5'b00010,
      S_MMU   = 5'b00100,
      S_WRITE = 5'b01000,
      S_ALU   = 5'b10000
   } machine_state_t;

   // Source driven onto mf
   typedef enum logic [1:0] {
      MF_NONE = 2'd0,
      MF_LC   = 2'd1,
      MF_MD   = 2'd2,
      MF_VMA  = 2'd3
   } mf_source_t;

   //////////////////////////////////////////////////////////////////////
   // Bundles
   //////////////////////////////////////////////////////////////////////

   // Microcode controls for the location counter
   typedef struct packed {
      logic destlc;
      logic lcinc;
      logic lc_byte_mode;
      logic int_enable;
      logic sequence_break;
   } lc_ctrl_t;

   // One-word read toward memory
   typedef struct packed {
      logic                         read;
      machine_word_pkg::word_addr_t addr;
   } mem_req_t;

   // Memory answer one cycle after the read
   typedef struct packed {
      logic                    valid;
      machine_word_pkg::word_t data;
   } mem_resp_t;

   // Extracted macroinstruction
   typedef struct packed {
      logic                        strobe;
      logic                        byte_mode;
      machine_word_pkg::halfword_t instr;
   } macro_instr_t;

endpackage

`default_nettype wire

//--- source/machine_word_pkg.sv
// Widths and vector types for addresses and data words of the fetch path.
// Referenced by scoped name from the control package and every RTL block.

`default_nettype none

package machine_word_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   // Byte address held in the location counter
   localparam int LC_WIDTH = 26;

   // Memory word and result bus width
   localparam int WORD_WIDTH = 32;

   // One macroinstruction
   localparam int HALF_WIDTH = 16;

   //////////////////////////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////////////////////////

   // LC byte address
   typedef logic [LC_WIDTH-1:0] lc_t;

   // Word address, LC bits 25:2
   typedef logic [LC_WIDTH-3:0] word_addr_t;

   // Memory data or result bus word
   typedef logic [WORD_WIDTH-1:0] word_t;

   // Halfword or zero-extended byte handed to decode
   typedef logic [HALF_WIDTH-1:0] halfword_t;

endpackage

`default_nettype wire
